// ==== common/scope_pkg.sv ====
//----------------------------------------------------------
// shared constants and enums for the digitizer core
// one frame is ten signed 12-bit samples per clock
// status codes are the raw acquisition state values
//----------------------------------------------------------
package scope_pkg;

	//----------------------------------------------------------
	// datapath sizes
	//----------------------------------------------------------
	localparam int SAMPLE_W        = 12;                       // signed adc sample
	localparam int FRAME_SAMPLES   = 10;                       // samples per clock
	localparam int FRAME_W         = SAMPLE_W * FRAME_SAMPLES; // 120 bits packed
	localparam int ADDR_W          = 10;                       // 1024 frame buffer
	localparam int CMD_BYTES       = 8;                        // fixed command length
	localparam int WORD_BYTES      = 4;                        // bytes per reply word
	localparam int WORDS_PER_FRAME = 5;                        // two samples per word
	localparam int FW_VERSION      = 18;                       // info command reply
	localparam int STATUS_W        = 8;                        // status code width

	//----------------------------------------------------------
	// host opcodes, byte 0 of a command
	//----------------------------------------------------------
	typedef enum logic [3:0] {
		OP_READ_EVENT = 4'd0, // stream the captured event
		OP_ARM        = 4'd1, // arm trigger, reply status
		OP_INFO       = 4'd2, // firmware version
		OP_TRIG_CFG   = 4'd8  // thresholds, offset, tot
	} cmd_op_e;

	typedef enum logic [1:0] {
		TRIG_NONE = 2'd0, // free run, capture at once
		TRIG_RISE = 2'd1,
		TRIG_FALL = 2'd2
	} trig_type_e;

	// values go to the host unchanged as the status byte
	typedef enum logic [STATUS_W-1:0] {
		ACQ_READY     = 8'd0,
		ACQ_RISE_ARM  = 8'd1,   // waiting for a sample below lower
		ACQ_RISE_FIRE = 8'd2,   // counting frames above upper
		ACQ_FALL_ARM  = 8'd3,
		ACQ_FALL_FIRE = 8'd4,
		ACQ_POST      = 8'd250, // post-trigger capture
		ACQ_DONE      = 8'd251  // event held for readout
	} acq_state_e;

endpackage

// ==== acquisition/sample_buffer.sv ====
//----------------------------------------------------------
// 1024 frame circular memory, read data one cycle late
//----------------------------------------------------------
`timescale 1ns/100ps

module sample_buffer import scope_pkg::*; (
	input  logic               clk,
	input  logic               i_wr_en,
	input  logic [ADDR_W-1:0]  i_wr_addr,
	input  logic [FRAME_W-1:0] i_wr_frame,
	input  logic [ADDR_W-1:0]  i_rd_addr,
	output logic [FRAME_W-1:0] o_rd_frame
);

	logic [FRAME_W-1:0] mem [1<<ADDR_W]; // block ram

	always_ff @(posedge clk) begin
		if (i_wr_en) mem[i_wr_addr] <= i_wr_frame;
		o_rd_frame <= mem[i_rd_addr]; // registered read port
	end

endmodule

// ==== acquisition/acq_trigger.sv ====
//----------------------------------------------------------
// threshold trigger and circular write addressing
// samples are compared in the cycle they arrive
// buffer writes stop while an event waits for readout
//----------------------------------------------------------
`timescale 1ns/100ps

module acq_trigger import scope_pkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	input  logic [FRAME_W-1:0]         i_frame,
	input  logic                       i_arm,          // honoured in ACQ_READY only
	input  trig_type_e                 i_trig_type,
	input  logic [15:0]                i_post_len,     // frames after trigger
	input  logic [7:0]                 i_tot,          // frames over threshold
	input  logic signed [SAMPLE_W-1:0] i_lower_th,
	input  logic signed [SAMPLE_W-1:0] i_upper_th,
	input  logic                       i_readout_done,
	output logic                       o_wr_en,
	output logic [ADDR_W-1:0]          o_wr_addr,
	output acq_state_e                 o_state,
	output logic [15:0]                o_event_count,
	output logic [7:0]                 o_trig_sample,
	output logic [ADDR_W-1:0]          o_trig_addr
);

	logic [FRAME_SAMPLES-1:0] above;    // sample > upper threshold
	logic [FRAME_SAMPLES-1:0] below;    // sample < lower threshold
	logic [FRAME_SAMPLES-1:0] fire_hit; // qualifying samples in fire states
	logic                     arm_hit;
	logic [7:0]               fire_idx; // highest qualifying sample
	logic [7:0]               tot_cnt;
	logic [15:0]              post_cnt;

	for (genvar g = 0; g < FRAME_SAMPLES; g++) begin : g_cmp
		assign above[g] = $signed(i_frame[g*SAMPLE_W +: SAMPLE_W]) > i_upper_th;
		assign below[g] = $signed(i_frame[g*SAMPLE_W +: SAMPLE_W]) < i_lower_th;
	end

	// falling edge uses the same logic with the thresholds swapped
	assign arm_hit  = (o_state == ACQ_RISE_ARM) ? |below : |above;
	assign fire_hit = (o_state == ACQ_RISE_FIRE) ? above : below;

	always_comb begin
		fire_idx = '0;
		for (int i = 0; i < FRAME_SAMPLES; i++) begin
			if (fire_hit[i]) fire_idx = 8'(i); // later index wins
		end
	end

	//----------------------------------------------------------
	// acquisition FSM
	//----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_state       <= ACQ_READY;
			o_wr_en       <= 1'b1;
			o_wr_addr     <= '0;
			o_event_count <= '0;
			o_trig_sample <= '0;
			o_trig_addr   <= '0;
			tot_cnt       <= '0;
			post_cnt      <= '0;
		end else begin
			if (o_wr_en) o_wr_addr <= o_wr_addr + 1'b1; // wraps at 1024
			unique case (o_state)
				ACQ_READY: begin
					tot_cnt  <= '0;
					post_cnt <= '0;
					if (i_arm) begin
						case (i_trig_type)
							TRIG_RISE: o_state <= ACQ_RISE_ARM;
							TRIG_FALL: o_state <= ACQ_FALL_ARM;
							default: begin // free run, trigger right here
								o_trig_addr   <= o_wr_addr;
								o_trig_sample <= '0;
								o_state       <= ACQ_POST;
							end
						endcase
					end
				end
				ACQ_RISE_ARM: if (arm_hit) o_state <= ACQ_RISE_FIRE;
				ACQ_FALL_ARM: if (arm_hit) o_state <= ACQ_FALL_FIRE;
				ACQ_RISE_FIRE, ACQ_FALL_FIRE: begin
					if (|fire_hit) begin
						tot_cnt <= tot_cnt + 8'd1;
						if (tot_cnt >= i_tot) begin // held long enough
							o_trig_addr   <= o_wr_addr;
							o_trig_sample <= fire_idx;
							o_state       <= ACQ_POST;
						end
					end else begin
						tot_cnt <= '0; // dropped back, rearm
						o_state <= (o_state == ACQ_RISE_FIRE) ? ACQ_RISE_ARM : ACQ_FALL_ARM;
					end
				end
				ACQ_POST: begin
					if (post_cnt < i_post_len) begin
						post_cnt <= post_cnt + 16'd1;
					end else begin
						o_event_count <= o_event_count + 16'd1;
						o_state       <= ACQ_DONE;
						o_wr_en       <= 1'b0; // freeze the buffer
					end
				end
				ACQ_DONE: begin
					if (i_readout_done) begin
						o_state <= ACQ_READY;
						o_wr_en <= 1'b1;
					end
				end
				default: begin
					o_state <= ACQ_READY;
					o_wr_en <= 1'b1;
				end
			endcase
		end
	end

	// the held event must never be overwritten, and capture must resume after it
	a_wr_en_state : assert property (@(posedge clk) disable iff (!rstn)
		o_wr_en == (o_state != ACQ_DONE));

endmodule

// ==== command/host_tx.sv ====
//----------------------------------------------------------
// reply word and event readout stream to the host
// event words pack two samples, zeros above each one
// o_tx_done marks the transfer of the last word
//----------------------------------------------------------
`timescale 1ns/100ps

module host_tx import scope_pkg::*; (
	input  logic               clk,
	input  logic               rstn,
	input  logic               i_tx_start,
	input  logic               i_tx_event,     // readout rather than one word
	input  logic [31:0]        i_tx_word,
	input  logic [31:0]        i_tx_len,       // bytes
	input  logic [ADDR_W-1:0]  i_rd_start,
	output logic [ADDR_W-1:0]  o_rd_addr,
	input  logic [FRAME_W-1:0] i_rd_frame,     // one cycle after o_rd_addr
	output logic               o_tvalid,
	input  logic               i_tready,
	output logic [31:0]        o_tdata,
	output logic [3:0]         o_tkeep,
	output logic               o_tlast,
	output logic               o_tx_done,
	output logic               o_readout_done
);

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_FETCH, // buffer read in progress
		TX_SEND
	} tx_state_e;

	tx_state_e   state;
	logic [31:0] remain;     // bytes still to send
	logic [2:0]  word_idx;   // word within the frame
	logic        event_mode;
	logic [31:0] word_q;     // single reply payload
	logic [31:0] frame_word;
	logic        xfer;

	assign xfer = o_tvalid && i_tready;

	// word k carries samples 2k and 2k+1
	assign frame_word = {{(16-SAMPLE_W){1'b0}},
		i_rd_frame[word_idx*2*SAMPLE_W + SAMPLE_W +: SAMPLE_W],
		{(16-SAMPLE_W){1'b0}},
		i_rd_frame[word_idx*2*SAMPLE_W +: SAMPLE_W]};

	assign o_tdata = event_mode ? frame_word : word_q;
	assign o_tlast = (remain <= 32'(WORD_BYTES));
	assign o_tkeep = (remain >= 32'(WORD_BYTES)) ? 4'b1111 : ~(4'b1111 << remain[1:0]);
	assign o_tx_done      = xfer && o_tlast;
	assign o_readout_done = o_tx_done && event_mode;

	always_ff @(posedge clk) begin
		if (state == TX_IDLE && i_tx_start) word_q <= i_tx_word;
	end

	//----------------------------------------------------------
	// stream FSM
	//----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= TX_IDLE;
			o_tvalid   <= 1'b0;
			remain     <= '0;
			word_idx   <= '0;
			event_mode <= 1'b0;
			o_rd_addr  <= '0;
		end else begin
			unique case (state)
				TX_IDLE: begin
					if (i_tx_start) begin
						remain     <= i_tx_len;
						event_mode <= i_tx_event;
						word_idx   <= '0;
						if (i_tx_event) begin
							o_rd_addr <= i_rd_start;
							state     <= TX_FETCH;
						end else begin
							o_tvalid <= 1'b1;
							state    <= TX_SEND;
						end
					end
				end
				TX_FETCH: begin // frame lands at this edge
					o_tvalid <= 1'b1;
					state    <= TX_SEND;
				end
				TX_SEND: begin
					if (xfer) begin
						remain <= remain - 32'(WORD_BYTES);
						if (o_tlast) begin
							o_tvalid <= 1'b0;
							state    <= TX_IDLE;
						end else if (event_mode && word_idx == 3'(WORDS_PER_FRAME - 1)) begin
							word_idx  <= '0;
							o_rd_addr <= o_rd_addr + 1'b1; // next frame, ring wrap
							o_tvalid  <= 1'b0;
							state     <= TX_FETCH;
						end else begin
							word_idx <= word_idx + 3'd1;
						end
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// a stalled word must not change under the host
	a_hold_stall : assert property (@(posedge clk) disable iff (!rstn)
		(o_tvalid && !i_tready) |=> $stable({o_tdata, o_tkeep, o_tlast}));

endmodule

// ==== command/cmd_engine.sv ====
//----------------------------------------------------------
// host command receiver and configuration registers
// commands are 8 bytes, byte 0 is the opcode
// next command is accepted only after the reply is sent
//----------------------------------------------------------
`timescale 1ns/100ps

module cmd_engine import scope_pkg::*; (
	input  logic                       clk,
	input  logic                       rstn,
	input  logic                       i_tvalid,
	output logic                       o_tready,
	input  logic [7:0]                 i_tdata,
	input  acq_state_e                 i_acq_state,
	input  logic [15:0]                i_event_count,
	input  logic [7:0]                 i_trig_sample,
	input  logic [ADDR_W-1:0]          i_trig_addr,
	input  logic                       i_tx_done,
	output logic                       o_arm,        // one cycle, after config update
	output trig_type_e                 o_trig_type,
	output logic [15:0]                o_post_len,
	output logic [7:0]                 o_tot,
	output logic signed [SAMPLE_W-1:0] o_lower_th,
	output logic signed [SAMPLE_W-1:0] o_upper_th,
	output logic                       o_tx_start,   // decode cycle only
	output logic                       o_tx_event,
	output logic [31:0]                o_tx_word,
	output logic [31:0]                o_tx_len,
	output logic [ADDR_W-1:0]          o_rd_start
);

	typedef enum logic [1:0] {
		CMD_IDLE,   // first cycle out of reset
		CMD_RX,     // collecting bytes
		CMD_DECODE,
		CMD_WAIT    // reply in flight
	} cmd_state_e;

	localparam int CNT_W = $clog2(CMD_BYTES);

	cmd_state_e              state;
	logic [7:0]              rx_byte [CMD_BYTES];
	logic [CNT_W-1:0]        rx_cnt;
	logic [ADDR_W-1:0]       pre_off;   // frames shown before the trigger
	logic [SAMPLE_W-1:0]     lo_base;
	logic [SAMPLE_W-1:0]     hi_base;
	logic                    op_known;  // upper opcode nibble clear
	cmd_op_e                 op;
	logic                    tx_open;

	assign o_tready = (state == CMD_RX);
	assign op       = cmd_op_e'(rx_byte[0][3:0]);
	assign op_known = (rx_byte[0][7:4] == 4'd0);
	assign lo_base  = {4'd0, rx_byte[1]} - {4'd0, rx_byte[2]} - SAMPLE_W'(128);
	assign hi_base  = {4'd0, rx_byte[1]} + {4'd0, rx_byte[2]} - SAMPLE_W'(128);
	assign o_rd_start = i_trig_addr - pre_off; // wraps in the ring

	//----------------------------------------------------------
	// reply selection, valid in the decode cycle
	//----------------------------------------------------------
	always_comb begin
		o_tx_start = 1'b0;
		o_tx_event = 1'b0;
		o_tx_word  = '0;
		o_tx_len   = 32'(WORD_BYTES); // single word reply
		if (state == CMD_DECODE && op_known) begin
			case (op)
				OP_READ_EVENT: begin
					o_tx_start = 1'b1;
					o_tx_event = 1'b1;
					o_tx_len   = {rx_byte[7], rx_byte[6], rx_byte[5], rx_byte[4]};
				end
				OP_ARM: begin
					o_tx_start = 1'b1;
					o_tx_word  = {i_event_count, i_trig_sample, i_acq_state}; // state before arm
				end
				OP_INFO: begin
					o_tx_start = 1'b1;
					o_tx_word  = 32'(FW_VERSION);
				end
				OP_TRIG_CFG: begin
					o_tx_start = 1'b1;
					o_tx_word  = 32'd8; // echo of the opcode
				end
				default: ;
			endcase
		end
	end

	// command bytes carry no reset
	always_ff @(posedge clk) begin
		if (state == CMD_RX && i_tvalid) rx_byte[rx_cnt] <= i_tdata;
	end

	//----------------------------------------------------------
	// receive FSM and configuration registers
	//----------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= CMD_IDLE;
			rx_cnt      <= '0;
			o_arm       <= 1'b0;
			o_trig_type <= TRIG_NONE;
			o_post_len  <= '0;
			o_tot       <= '0;
			o_lower_th  <= '0;
			o_upper_th  <= '0;
			pre_off     <= '0;
			tx_open     <= 1'b0;
		end else begin
			o_arm <= 1'b0;
			if (o_tx_start) tx_open <= 1'b1;
			else if (i_tx_done) tx_open <= 1'b0;
			unique case (state)
				CMD_IDLE: state <= CMD_RX;
				CMD_RX: begin
					if (i_tvalid) begin
						if (rx_cnt == CNT_W'(CMD_BYTES - 1)) begin
							rx_cnt <= '0;
							state  <= CMD_DECODE;
						end else begin
							rx_cnt <= rx_cnt + 1'b1;
						end
					end
				end
				CMD_DECODE: begin
					if (op_known && op == OP_ARM) begin
						o_trig_type <= trig_type_e'(rx_byte[1][1:0]);
						o_post_len  <= {rx_byte[5], rx_byte[4]};
						o_arm       <= 1'b1; // config settles this edge
					end
					if (op_known && op == OP_TRIG_CFG) begin
						o_lower_th <= $signed({lo_base[SAMPLE_W-5:0], 4'h8}); // x*16+8
						o_upper_th <= $signed({hi_base[SAMPLE_W-5:0], 4'h8});
						pre_off    <= {rx_byte[3][1:0], rx_byte[4]};
						o_tot      <= rx_byte[5];
					end
					state <= o_tx_start ? CMD_WAIT : CMD_RX; // unknown op sends nothing
				end
				CMD_WAIT: if (i_tx_done) state <= CMD_RX;
				default: state <= CMD_RX;
			endcase
		end
	end

	// host_tx handles one transfer at a time
	a_no_overlap : assert property (@(posedge clk) disable iff (!rstn)
		o_tx_start |-> !tx_open);

endmodule

// ==== design/scope_top.sv ====
//----------------------------------------------------------
// digitizer core top, single clock domain
// i_frame is sampled every cycle, there is no valid
//----------------------------------------------------------
`timescale 1ns/100ps

module scope_top import scope_pkg::*; (
	input  logic               clk,
	input  logic               rstn,
	// command byte stream from host
	input  logic               i_tvalid,
	output logic               o_tready,
	input  logic [7:0]         i_tdata,
	// reply word stream to host
	output logic               o_tvalid,
	input  logic               i_tready,
	output logic [31:0]        o_tdata,
	output logic [3:0]         o_tkeep,
	output logic               o_tlast,
	// adc samples
	input  logic [FRAME_W-1:0] i_frame
);

	//----------------------------------------------------------
	// internal links
	//----------------------------------------------------------
	logic                       arm;
	trig_type_e                 trig_type;
	logic [15:0]                post_len;
	logic [7:0]                 tot;
	logic signed [SAMPLE_W-1:0] lower_th;
	logic signed [SAMPLE_W-1:0] upper_th;
	acq_state_e                 acq_state;
	logic [15:0]                event_count;
	logic [7:0]                 trig_sample;
	logic [ADDR_W-1:0]          trig_addr;
	logic                       tx_start;
	logic                       tx_event;
	logic [31:0]                tx_word;
	logic [31:0]                tx_len;
	logic [ADDR_W-1:0]          rd_start;
	logic                       tx_done;
	logic                       readout_done;
	logic [ADDR_W-1:0]          rd_addr;
	logic [FRAME_W-1:0]         rd_frame;
	logic                       wr_en;
	logic [ADDR_W-1:0]          wr_addr;

	cmd_engine u_cmd (
		.clk(clk), .rstn(rstn),
		.i_tvalid(i_tvalid), .o_tready(o_tready), .i_tdata(i_tdata),
		.i_acq_state(acq_state), .i_event_count(event_count),
		.i_trig_sample(trig_sample), .i_trig_addr(trig_addr),
		.i_tx_done(tx_done),
		.o_arm(arm), .o_trig_type(trig_type), .o_post_len(post_len), .o_tot(tot),
		.o_lower_th(lower_th), .o_upper_th(upper_th),
		.o_tx_start(tx_start), .o_tx_event(tx_event), .o_tx_word(tx_word),
		.o_tx_len(tx_len), .o_rd_start(rd_start)
	);

	host_tx u_tx (
		.clk(clk), .rstn(rstn),
		.i_tx_start(tx_start), .i_tx_event(tx_event), .i_tx_word(tx_word),
		.i_tx_len(tx_len), .i_rd_start(rd_start),
		.o_rd_addr(rd_addr), .i_rd_frame(rd_frame),
		.o_tvalid(o_tvalid), .i_tready(i_tready), .o_tdata(o_tdata),
		.o_tkeep(o_tkeep), .o_tlast(o_tlast),
		.o_tx_done(tx_done), .o_readout_done(readout_done)
	);

	acq_trigger u_acq (
		.clk(clk), .rstn(rstn), .i_frame(i_frame),
		.i_arm(arm), .i_trig_type(trig_type), .i_post_len(post_len), .i_tot(tot),
		.i_lower_th(lower_th), .i_upper_th(upper_th), .i_readout_done(readout_done),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_state(acq_state),
		.o_event_count(event_count), .o_trig_sample(trig_sample), .o_trig_addr(trig_addr)
	);

	sample_buffer u_buf (
		.clk(clk),
		.i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_frame(i_frame),
		.i_rd_addr(rd_addr), .o_rd_frame(rd_frame)
	);

endmodule

// ==== testbench/tb_clkgen.sv ====
//----------------------------------------------------------
// testbench clock and reset, 10 ns period
// rstn is held low for 8 rising edges, released on an edge
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_clkgen (
	output logic o_clk,
	output logic o_rstn
);

	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk; // 100 MHz
	end

	initial begin
		o_rstn = 1'b0;
		repeat (8) @(posedge o_clk);
		o_rstn <= 1'b1; // release on a rising edge
	end

endmodule

// ==== testbench/tb_scope.sv ====
//----------------------------------------------------------
// top testbench for the digitizer core
// every frame has sample k = base + k, so readout words
// always carry a high sample one above the low sample
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_scope;

	localparam int SEED        = 32'h2d35;
	localparam int EST_CYCLES  = 30 + 40 + 80 + 100 + 150 + 100; // per test estimates
	localparam int WATCHDOG_NS = 20 * EST_CYCLES * 10;

	logic         clk;
	logic         rstn;
	logic         i_tvalid;
	logic         o_tready;
	logic [7:0]   i_tdata;
	logic         o_tvalid;
	logic         i_tready;
	logic [31:0]  o_tdata;
	logic [3:0]   o_tkeep;
	logic         o_tlast;
	logic [119:0] i_frame;

	int          errors;
	int          tests_run;
	int          tests_failed;
	logic        free_run;    // random base per cycle
	logic [11:0] fix_base;    // base used when not free running
	logic        in_readout;  // event words on the stream
	logic        stall_on;    // random i_tready during replies
	logic [11:0] lower_th;
	logic [11:0] upper_th;

	tb_clkgen u_clkgen (.o_clk(clk), .o_rstn(rstn));

	scope_top dut_i (
		.clk(clk), .rstn(rstn),
		.i_tvalid(i_tvalid), .o_tready(o_tready), .i_tdata(i_tdata),
		.o_tvalid(o_tvalid), .i_tready(i_tready), .o_tdata(o_tdata),
		.o_tkeep(o_tkeep), .o_tlast(o_tlast), .i_frame(i_frame)
	);

	//----------------------------------------------------------
	// protocol assertions
	//----------------------------------------------------------
	a_rst_idle : assert property (@(posedge clk) !rstn |-> !o_tvalid)
		else begin $display("reply valid seen during reset"); errors++; end

	a_rdy_after_rst : assert property (@(posedge clk) $rose(rstn) |=> o_tready)
		else begin $display("o_tready not high on the cycle after reset"); errors++; end

	a_stall_hold : assert property (@(posedge clk) disable iff (!rstn)
		(o_tvalid && !i_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tkeep)
		&& $stable(o_tlast)))
		else begin $display("reply word changed or dropped while stalled"); errors++; end

	a_word_fmt : assert property (@(posedge clk) disable iff (!rstn)
		(o_tvalid && in_readout) |-> (o_tdata[31:28] == 4'h0 && o_tdata[15:12] == 4'h0
		&& o_tdata[27:16] == 12'(o_tdata[11:0] + 12'd1)))
		else begin $display("ERROR o_tdata bad sample pair %h", o_tdata); errors++; end

	//----------------------------------------------------------
	// frame source and watchdog
	//----------------------------------------------------------
	function automatic logic [119:0] build_frame(input logic [11:0] base);
		logic [119:0] f;
		for (int k = 0; k < 10; k++) f[k*12 +: 12] = 12'(base + 12'(k));
		return f;
	endfunction

	always @(posedge clk) begin
		if (free_run) i_frame <= build_frame(12'($urandom % 4086)); // no 12-bit wrap
		else i_frame <= build_frame(fix_base);
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, run did not finish");
		$display("*** TEST FAILED ***");
		$finish;
	end

	//----------------------------------------------------------
	// helpers
	//----------------------------------------------------------
	// threshold rule (b1 -/+ b2 - 128) * 16 + 8
	function automatic logic [11:0] threshold(input int b1, input int b2, input bit upper);
		int v;
		v = (upper ? b1 + b2 : b1 - b2) - 128;
		return 12'(v * 16 + 8);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp)
			else begin $display("ERROR %s got %h expected %h", name, got, exp); errors++; end
	endtask

	task automatic check_cond(input bit ok, input string what);
		assert (ok) else begin $display("%s", what); errors++; end
	endtask

	// kind 0 unknown opcode, 1 single reply, 2 event readout
	task automatic send_cmd(input logic [63:0] cmd, input int kind);
		bit ok;
		@(posedge clk);
		for (int i = 0; i < 8; i++) begin
			i_tvalid <= 1'b1;
			i_tdata  <= cmd[8*i +: 8];
			ok = 1'b0;
			while (!ok) begin
				@(negedge clk);
				ok = o_tready;
				@(posedge clk);
			end
		end
		i_tvalid <= 1'b0;
		@(negedge clk); // decode cycle
		check_cond(!o_tready, "o_tready high in the decode cycle");
		if (kind == 1) check_cond(!o_tvalid, "reply valid one cycle too early");
		if (kind != 2) @(negedge clk);
		if (kind == 1) check_cond(o_tvalid, "reply valid not on the second cycle");
		if (kind == 0) check_cond(o_tready && !o_tvalid, "unknown opcode not skipped");
	endtask

	// entered and left at a falling edge
	task automatic get_word(output logic [31:0] data, output logic [3:0] keep,
		output logic last);
		bit got;
		got = 1'b0;
		while (!got) begin
			if (o_tvalid && i_tready) begin
				data = o_tdata;
				keep = o_tkeep;
				last = o_tlast;
				got  = 1'b1;
			end
			@(posedge clk);
			i_tready <= stall_on ? 1'($urandom % 2) : 1'b1;
			@(negedge clk);
		end
	endtask

	task automatic read_event(input int len);
		logic [31:0] d;
		logic [3:0]  k;
		logic        l;
		int          n_exp;
		int          n;
		n_exp = (len + 3) / 4;
		n     = 0;
		l     = 1'b0;
		in_readout = 1'b1;
		stall_on   = 1'b1;
		send_cmd({32'(len), 24'h0, 8'h00}, 2);
		while (!l && n < n_exp) begin
			get_word(d, k, l);
			n++;
			check_val("o_tlast", 32'(l), 32'(n == n_exp));
			if (n < n_exp) check_val("o_tkeep", 32'(k), 32'hf);
		end
		check_val("word count", 32'(n), 32'(n_exp));
		check_val("o_tkeep last", 32'(k), (len % 4 == 0) ? 32'hf : 32'((1 << (len % 4)) - 1));
		stall_on   = 1'b0;
		in_readout = 1'b0;
		@(posedge clk);
		i_tready <= 1'b1;
		@(negedge clk);
	endtask

	task automatic arm_status(input logic [1:0] trig, output logic [31:0] status);
		logic [3:0] k;
		logic       l;
		send_cmd({16'h0, 16'd4, 16'h0, 6'h0, trig, 8'h01}, 1); // post length 4
		get_word(status, k, l);
		check_val("o_tkeep", 32'(k), 32'hf);
		check_val("o_tlast", 32'(l), 32'h1);
	endtask

	task automatic end_test(input int num, input string name, input int err_before);
		tests_run++;
		if (errors != err_before) tests_failed++;
		$display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAILED");
	endtask

	//----------------------------------------------------------
	// test sequence
	//----------------------------------------------------------
	initial begin
		logic [31:0] d;
		logic [3:0]  k;
		logic        l;
		int          e0;
		void'($urandom(SEED));
		errors     = 0;
		tests_run  = 0;
		tests_failed = 0;
		i_tvalid   = 1'b0;
		i_tdata    = 8'h00;
		i_tready   = 1'b1;
		i_frame    = '0;
		free_run   = 1'b1;
		fix_base   = 12'd0;
		in_readout = 1'b0;
		stall_on   = 1'b0;
		lower_th   = threshold(160, 16, 1'b0);
		upper_th   = threshold(160, 16, 1'b1);
		wait (rstn === 1'b1);
		@(negedge clk);

		// reset and info
		e0 = errors;
		send_cmd(64'h02, 1);
		get_word(d, k, l);
		check_val("o_tdata", d, 32'h12);
		check_val("o_tkeep", 32'(k), 32'hf);
		check_val("o_tlast", 32'(l), 32'h1);
		end_test(1, "reset and info", e0);

		// trigger config, pre offset 5, tot 2, then an unknown opcode
		e0 = errors;
		send_cmd({16'h0, 8'd2, 8'd5, 8'd0, 8'd16, 8'd160, 8'h08}, 1);
		get_word(d, k, l);
		check_val("o_tdata", d, 32'h8);
		send_cmd(64'h05, 0);
		end_test(2, "config and unknown opcode", e0);

		// free-running capture
		e0 = errors;
		arm_status(2'd0, d);
		check_val("status", d, 32'h0);
		repeat (20) @(posedge clk);
		@(negedge clk);
		arm_status(2'd0, d);
		check_val("status", d, {16'd1, 8'd0, 8'd251});
		end_test(3, "free-run capture", e0);

		e0 = errors;
		read_event(37);
		end_test(4, "event readout with stalls", e0);

		// rising trigger, flat below the lower threshold first
		e0 = errors;
		@(posedge clk);
		fix_base <= 12'(lower_th - 12'd20);
		free_run <= 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arm_status(2'd1, d);
		check_val("status", d, {16'd1, 8'd0, 8'd0});
		repeat (4) @(posedge clk);
		fix_base <= 12'(upper_th - 12'd8); // only sample 9 above upper
		repeat (2) @(posedge clk);
		fix_base <= 12'(lower_th - 12'd20);
		repeat (6) @(posedge clk);
		@(negedge clk);
		arm_status(2'd1, d);
		check_cond(d[7:0] == 8'd1 || d[7:0] == 8'd2, "short pulse changed the trigger state");
		@(posedge clk);
		fix_base <= 12'(upper_th - 12'd8);
		repeat (6) @(posedge clk);
		fix_base <= 12'(lower_th - 12'd20);
		repeat (20) @(posedge clk);
		@(negedge clk);
		arm_status(2'd1, d);
		check_val("status", d, {16'd2, 8'd9, 8'd251});
		end_test(5, "rising trigger", e0);

		e0 = errors;
		read_event(50);
		arm_status(2'd0, d);
		check_val("status", 32'(d[7:0]), 32'h0);
		end_test(6, "second readout and rearm", e0);

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
common/scope_pkg.sv
acquisition/sample_buffer.sv
acquisition/acq_trigger.sv
command/host_tx.sv
command/cmd_engine.sv
design/scope_top.sv
testbench/tb_clkgen.sv
testbench/tb_scope.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the digitizer core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_scope -f compile.f \
	-o sim_scope > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_scope > sim.log 2>&1
grep -qF "*** TEST PASSED ***" sim.log && echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
